//--- rtl/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// serial line, clocks per bit
`define CLKS_PER_BIT        8

// key queue entries
`define KEY_QUEUE_DEPTH     4

// aim bar sweep
`define BAR_X_START         15
`define BAR_X_END           520
`define BAR_STEP            8
`define BAR_STEP_CYCLES     4

// scoring zones, bounds inclusive, narrowest first
`define ZONE_CRIT_LO        305
`define ZONE_CRIT_HI        325
`define ZONE_GOOD_LO        220
`define ZONE_GOOD_HI        395
`define ZONE_FAIR_LO        160
`define ZONE_FAIR_HI        455
`define ZONE_POOR_LO        115
`define ZONE_POOR_HI        500

// damage per zone
`define DMG_CRIT            100
`define DMG_GOOD            50
`define DMG_FAIR            10
`define DMG_POOR            5

`define MONSTER_TOTAL_HP    200
`define ATTACK_CYCLES       64

`endif

//--- rtl/key_pkg.sv
`default_nettype none

`include "game_settings.svh"

package key_pkg;

    // raw byte off the serial line
    typedef logic [7:0] key_byte_t;

    // keys the battle screen reacts to, encoded as their ascii byte
    typedef enum logic [7:0] {
        KEY_ENTER = 8'h0D,
        KEY_SPACE = 8'h20,
        KEY_A     = 8'h61,
        KEY_D     = 8'h64
    } key_code_t;

    // baud counter, counts 0 .. CLKS_PER_BIT-1
    typedef logic [$clog2(`CLKS_PER_BIT)-1:0] baud_cnt_t;

    // true for bytes that map onto a key_code_t value
    function automatic logic is_key(key_byte_t b);
        logic hit;
        case (b)
            KEY_ENTER, KEY_SPACE, KEY_A, KEY_D: hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

//--- rtl/battle_pkg.sv
`default_nettype none

package battle_pkg;

    //////////////////////////////////////////////////////////////////////
    // battle flow
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_HOME   = 2'd0,
        ST_MENU   = 2'd1,
        ST_FIGHT  = 2'd2,
        ST_ATTACK = 2'd3
    } battle_state_t;

    // menu cursor
    typedef logic [1:0] cursor_t;

    localparam cursor_t CUR_FIGHT = 2'd0;
    localparam cursor_t CUR_ACT   = 2'd1;
    localparam cursor_t CUR_ITEM  = 2'd2;
    localparam cursor_t CUR_MERCY = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // screen and stats
    //////////////////////////////////////////////////////////////////////

    // horizontal screen position
    typedef logic [9:0] coord_t;

    // hit points
    typedef logic [15:0] hp_t;

endpackage

`default_nettype wire

//--- rtl/uart_key_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module uart_key_rx (
    input  wire                 i_clk,
    input  wire                 cursor_position_rst,
    input  wire                 i_rx,
    output logic                o_req,
    output key_pkg::key_code_t  o_key,
    input  wire                 i_ack
);
    import key_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    localparam baud_cnt_t HALF_BIT = baud_cnt_t'(`CLKS_PER_BIT / 2 - 1);
    localparam baud_cnt_t FULL_BIT = baud_cnt_t'(`CLKS_PER_BIT - 1);

    rx_state_t  state;
    baud_cnt_t  baud_cnt;
    logic [2:0] bit_idx;
    logic       rx_meta;
    logic       rx_sync;
    key_byte_t  shift;
    logic       data_tick;
    logic       stop_tick;
    logic       offer;

    assign data_tick = (state == RX_DATA) && (baud_cnt == FULL_BIT);
    assign stop_tick = (state == RX_STOP) && (baud_cnt == FULL_BIT);

    // valid stop bit, known key and an idle handshake
    assign offer = stop_tick && rx_sync && is_key(shift) && !o_req && !i_ack;

    always_ff @(posedge i_clk) begin
        if (cursor_position_rst) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            o_req    <= 1'b0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;

            // four-phase offer
            if (offer) begin
                o_req <= 1'b1;
            end else if (o_req && i_ack) begin
                o_req <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // check start bit at its middle
                    if (baud_cnt == HALF_BIT) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (data_tick) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (stop_tick) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge i_clk) begin
        if (data_tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (offer) begin
            o_key <= key_code_t'(shift);
        end
    end

endmodule

`default_nettype wire

//--- rtl/key_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module key_queue (
    input  wire                     clk,
    input  wire                     cursor_position_rst,
    input  wire                     i_req,
    input  wire key_pkg::key_code_t i_key,
    output logic                    o_ack,
    output logic                    o_req,
    output key_pkg::key_code_t      o_key,
    input  wire                     i_ack
);
    import key_pkg::*;

    localparam int DEPTH = `KEY_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    key_code_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;
    logic             offer;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    // accept side, ack held back while full
    assign push  = i_req && !o_ack && !full;
    // offer side, one key per handshake
    assign pop   = o_req && i_ack;
    assign offer = !o_req && !i_ack && (count != '0);

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_ack  <= 1'b0;
            o_req  <= 1'b0;
        end else begin
            if (push) begin
                o_ack  <= 1'b1;
                wr_ptr <= next_ptr(wr_ptr);
            end else if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end

            if (offer) begin
                o_req <= 1'b1;
            end else if (pop) begin
                o_req  <= 1'b0;
                rd_ptr <= next_ptr(rd_ptr);
            end

            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_key;
        end
        if (offer) begin
            o_key <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/battle_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module battle_controller (
    input  wire                       clk,
    input  wire                       cursor_position_rst,
    input  wire                       i_req,
    input  wire key_pkg::key_code_t   i_key,
    output logic                      o_ack,
    output battle_pkg::battle_state_t o_state,
    output battle_pkg::cursor_t       o_cursor,
    output battle_pkg::coord_t        o_bar_x,
    output battle_pkg::hp_t           o_monster_hp
);
    import key_pkg::*;
    import battle_pkg::*;

    localparam int STEP_W = (`BAR_STEP_CYCLES > 1) ? $clog2(`BAR_STEP_CYCLES) : 1;
    localparam int ATK_W  = (`ATTACK_CYCLES > 1) ? $clog2(`ATTACK_CYCLES) : 1;

    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`BAR_STEP_CYCLES - 1);
    localparam logic [ATK_W-1:0]  ATK_LAST  = ATK_W'(`ATTACK_CYCLES - 1);
    localparam hp_t               HP_FULL   = hp_t'(`MONSTER_TOTAL_HP);

    logic              key_fire;
    logic [STEP_W-1:0] step_cnt;
    logic [ATK_W-1:0]  atk_cnt;
    hp_t               damage;

    // narrowest zone wins, nothing outside the outer zone
    function automatic hp_t zone_damage(coord_t x);
        hp_t d;
        if (x >= `ZONE_CRIT_LO && x <= `ZONE_CRIT_HI) begin
            d = hp_t'(`DMG_CRIT);
        end else if (x >= `ZONE_GOOD_LO && x <= `ZONE_GOOD_HI) begin
            d = hp_t'(`DMG_GOOD);
        end else if (x >= `ZONE_FAIR_LO && x <= `ZONE_FAIR_HI) begin
            d = hp_t'(`DMG_FAIR);
        end else if (x >= `ZONE_POOR_LO && x <= `ZONE_POOR_HI) begin
            d = hp_t'(`DMG_POOR);
        end else begin
            d = '0;
        end
        return d;
    endfunction

    assign damage = zone_damage(o_bar_x);

    // key is consumed on the edge that raises ack
    assign key_fire = i_req && !o_ack;

    //////////////////////////////////////////////////////////////////////
    // handshake and battle flow
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cursor_position_rst) begin
            o_ack        <= 1'b0;
            o_state      <= ST_HOME;
            o_cursor     <= CUR_FIGHT;
            o_bar_x      <= coord_t'(`BAR_X_START);
            o_monster_hp <= HP_FULL;
            step_cnt     <= '0;
            atk_cnt      <= '0;
        end else begin
            if (key_fire) begin
                o_ack <= 1'b1;
            end else if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end

            atk_cnt <= '0;

            case (o_state)
                ST_HOME: begin
                    if (key_fire && i_key == KEY_ENTER) begin
                        o_state  <= ST_MENU;
                        o_cursor <= CUR_FIGHT;
                    end
                end
                ST_MENU: begin
                    if (key_fire) begin
                        if (i_key == KEY_A && o_cursor != CUR_FIGHT) begin
                            o_cursor <= o_cursor - cursor_t'(1);
                        end else if (i_key == KEY_D && o_cursor != CUR_MERCY) begin
                            o_cursor <= o_cursor + cursor_t'(1);
                        end else if (i_key == KEY_ENTER && o_cursor == CUR_FIGHT) begin
                            o_state  <= ST_FIGHT;
                            o_bar_x  <= coord_t'(`BAR_X_START);
                            step_cnt <= '0;
                        end else if (i_key == KEY_ENTER && o_cursor == CUR_MERCY) begin
                            o_state      <= ST_HOME;
                            o_monster_hp <= HP_FULL;
                        end
                    end
                end
                ST_FIGHT: begin
                    if (key_fire && i_key == KEY_SPACE) begin
                        // kill restarts from home
                        if (o_monster_hp <= damage) begin
                            o_state      <= ST_HOME;
                            o_monster_hp <= HP_FULL;
                        end else begin
                            o_monster_hp <= o_monster_hp - damage;
                            o_state      <= ST_ATTACK;
                        end
                    end else if (o_bar_x > coord_t'(`BAR_X_END)) begin
                        o_state <= ST_ATTACK;
                    end else if (step_cnt == STEP_LAST) begin
                        step_cnt <= '0;
                        o_bar_x  <= o_bar_x + coord_t'(`BAR_STEP);
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: begin
                    // monster turn, fixed length
                    if (atk_cnt == ATK_LAST) begin
                        o_state  <= ST_MENU;
                        o_cursor <= CUR_FIGHT;
                    end else begin
                        atk_cnt <= atk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/battle_top.sv
`timescale 1ns/1ps
`default_nettype none

module battle_top (
    input  wire                       clk,
    input  wire                       cursor_position_rst,
    input  wire                       i_rx,
    output battle_pkg::battle_state_t o_state,
    output battle_pkg::cursor_t       o_cursor,
    output battle_pkg::coord_t        o_bar_x,
    output battle_pkg::hp_t           o_monster_hp
);
    import key_pkg::*;

    // receiver to queue
    logic      rx_req;
    key_code_t rx_key;
    logic      rx_ack;

    // queue to controller
    logic      q_req;
    key_code_t q_key;
    logic      q_ack;

    uart_key_rx u_rx (
        .i_clk               (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_rx                (i_rx),
        .o_req               (rx_req),
        .o_key               (rx_key),
        .i_ack               (rx_ack)
    );

    key_queue u_queue (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_req               (rx_req),
        .i_key               (rx_key),
        .o_ack               (rx_ack),
        .o_req               (q_req),
        .o_key               (q_key),
        .i_ack               (q_ack)
    );

    battle_controller u_ctrl (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_req               (q_req),
        .i_key               (q_key),
        .o_ack               (q_ack),
        .o_state             (o_state),
        .o_cursor            (o_cursor),
        .o_bar_x             (o_bar_x),
        .o_monster_hp        (o_monster_hp)
    );

endmodule

`default_nettype wire

//--- verif/battle_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module battle_chk (
    input wire                            clk,
    input wire                            cursor_position_rst,
    input wire                            i_rx_req,
    input wire key_pkg::key_code_t        i_rx_key,
    input wire                            i_q_req,
    input wire key_pkg::key_code_t        i_q_key,
    input wire                            i_q_ack,
    input wire battle_pkg::battle_state_t i_state,
    input wire battle_pkg::cursor_t       i_cursor,
    input wire battle_pkg::coord_t        i_bar_x,
    input wire battle_pkg::hp_t           i_monster_hp
);
    import key_pkg::*;
    import battle_pkg::*;

    int   fail_count = 0;
    int   atk_len;
    logic key_fire;

    // zone table, narrowest zone first, bounds inclusive
    function automatic hp_t zone_hit_damage(coord_t x);
        if (x >= coord_t'(`ZONE_CRIT_LO) && x <= coord_t'(`ZONE_CRIT_HI))
            return hp_t'(`DMG_CRIT);
        if (x >= coord_t'(`ZONE_GOOD_LO) && x <= coord_t'(`ZONE_GOOD_HI))
            return hp_t'(`DMG_GOOD);
        if (x >= coord_t'(`ZONE_FAIR_LO) && x <= coord_t'(`ZONE_FAIR_HI))
            return hp_t'(`DMG_FAIR);
        if (x >= coord_t'(`ZONE_POOR_LO) && x <= coord_t'(`ZONE_POOR_HI))
            return hp_t'(`DMG_POOR);
        return '0;
    endfunction

    // controller takes the key on the cycle its ack rises
    assign key_fire = i_q_req && !i_q_ack;

    // cycles spent so far in the monster turn
    always_ff @(posedge clk) begin
        if (cursor_position_rst || i_state != ST_ATTACK) begin
            atk_len <= 0;
        end else begin
            atk_len <= atk_len + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // key path and menu
    //////////////////////////////////////////////////////////////////////

    a_rx_known: assert property (@(posedge clk) disable iff (cursor_position_rst)
        $rose(i_rx_req) |-> (i_rx_key inside {KEY_ENTER, KEY_SPACE, KEY_A, KEY_D}))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: unknown key offered", $time);
        end

    a_cur_step: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (i_state == ST_MENU) |=> (i_state != ST_MENU)
            || ((int'(i_cursor) - int'($past(i_cursor))) inside {-1, 0, 1}))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: cursor jumped", $time);
        end

    a_cur_edge: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (key_fire && i_state == ST_MENU
            && ((i_q_key == KEY_A && i_cursor == 2'd0) || (i_q_key == KEY_D && i_cursor == 2'd3)))
        |=> $stable(i_cursor))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: cursor left range", $time);
        end

    a_home_enter: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (key_fire && i_state == ST_HOME && i_q_key == KEY_ENTER)
        |=> (i_state == ST_MENU && i_cursor == 2'd0))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: home enter", $time);
        end

    a_mercy: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (key_fire && i_state == ST_MENU && i_cursor == 2'd3 && i_q_key == KEY_ENTER)
        |=> (i_state == ST_HOME))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: mercy enter", $time);
        end

    a_fight_enter: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (key_fire && i_state == ST_MENU && i_cursor == 2'd0 && i_q_key == KEY_ENTER)
        |=> (i_state == ST_FIGHT && i_bar_x == coord_t'(`BAR_X_START)))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: fight enter", $time);
        end

    //////////////////////////////////////////////////////////////////////
    // fight, damage and monster turn
    //////////////////////////////////////////////////////////////////////

    a_damage: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (i_monster_hp < $past(i_monster_hp))
        |-> (hp_t'($past(i_monster_hp) - i_monster_hp) == zone_hit_damage($past(i_bar_x))))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: wrong damage", $time);
        end

    a_miss: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (i_state == ST_FIGHT && i_bar_x > coord_t'(`BAR_X_END)
            && !(key_fire && i_q_key == KEY_SPACE))
        |=> (i_state == ST_ATTACK && $stable(i_monster_hp)))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: missed sweep", $time);
        end

    a_kill: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (key_fire && i_state == ST_FIGHT && i_q_key == KEY_SPACE
            && i_monster_hp <= zone_hit_damage(i_bar_x))
        |=> (i_state == ST_HOME && i_monster_hp == hp_t'(`MONSTER_TOTAL_HP)))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: kill not handled", $time);
        end

    a_atk_hold: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (i_state == ST_ATTACK && atk_len < `ATTACK_CYCLES - 1) |=> (i_state == ST_ATTACK))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: attack too short", $time);
        end

    a_atk_end: assert property (@(posedge clk) disable iff (cursor_position_rst)
        (i_state == ST_ATTACK && atk_len == `ATTACK_CYCLES - 1)
        |=> (i_state == ST_MENU && i_cursor == 2'd0))
        else begin
            fail_count = fail_count + 1;
            $error("[FAIL] %0t ns: attack end", $time);
        end

endmodule

bind battle_top battle_chk u_chk (
    .clk                 (clk),
    .cursor_position_rst (cursor_position_rst),
    .i_rx_req            (rx_req),
    .i_rx_key            (rx_key),
    .i_q_req             (q_req),
    .i_q_key             (q_key),
    .i_q_ack             (q_ack),
    .i_state             (o_state),
    .i_cursor            (o_cursor),
    .i_bar_x             (o_bar_x),
    .i_monster_hp        (o_monster_hp)
);

`default_nettype wire

//--- verif/battle_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module battle_tb;
    import key_pkg::*;
    import battle_pkg::*;

    localparam int BYTE_CYCLES  = 10 * `CLKS_PER_BIT;
    localparam int SWEEP_CYCLES = ((`BAR_X_END - `BAR_X_START) / `BAR_STEP + 2) * `BAR_STEP_CYCLES;
    localparam int MAX_FIGHTS   = 20;
    localparam int MAX_BYTES    = 12 + 2 * MAX_FIGHTS;
    // bytes, then a sweep and a monster turn per fight, doubled for margin
    localparam int MAX_CYCLES   = 2 * (MAX_BYTES * BYTE_CYCLES
                                  + (MAX_FIGHTS + 1) * (SWEEP_CYCLES + `ATTACK_CYCLES));

    logic          clk = 1'b0;
    logic          cursor_position_rst;
    logic          rx;
    battle_state_t o_state;
    cursor_t       o_cursor;
    coord_t        o_bar_x;
    hp_t           o_monster_hp;

    int   tb_errors = 0;
    int   cycle_cnt = 0;
    int   fights;
    int   delay;
    int   total;
    logic killed;

    battle_top UUT (
        .clk                 (clk),
        .cursor_position_rst (cursor_position_rst),
        .i_rx                (rx),
        .o_state             (o_state),
        .o_cursor            (o_cursor),
        .o_bar_x             (o_bar_x),
        .o_monster_hp        (o_monster_hp)
    );

    always #20 clk = ~clk;

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input key_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic wait_state(input battle_state_t target, input int limit, input string what);
        int n;
        n = 0;
        while (o_state != target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (o_state != target) begin
            tb_errors++;
            $display("error at %0t ns: state never became %s after %s",
                     $time, target.name(), what);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h4af));
        cursor_position_rst <= 1'b1;
        rx <= 1'b1;
        repeat (3) @(posedge clk);
        cursor_position_rst <= 1'b0;

        // 'w' must not reach the controller
        send_byte(8'h77);
        repeat (BYTE_CYCLES) @(negedge clk);

        send_byte(KEY_ENTER);
        wait_state(ST_MENU, BYTE_CYCLES, "enter at home");

        // cursor walk, both ends included
        send_byte(KEY_A);
        repeat (4) send_byte(KEY_D);
        send_byte(KEY_ENTER);
        wait_state(ST_HOME, BYTE_CYCLES, "enter on mercy");

        // fight with no hit
        send_byte(KEY_ENTER);
        wait_state(ST_MENU, BYTE_CYCLES, "enter at home");
        send_byte(KEY_ENTER);
        wait_state(ST_FIGHT, BYTE_CYCLES, "enter on fight");
        wait_state(ST_ATTACK, SWEEP_CYCLES, "full sweep");
        wait_state(ST_MENU, `ATTACK_CYCLES + 4, "monster turn");

        // random hits until the monster falls
        killed = 1'b0;
        fights = 0;
        while (!killed && fights < MAX_FIGHTS) begin
            send_byte(KEY_ENTER);
            wait_state(ST_FIGHT, BYTE_CYCLES, "enter on fight");
            delay = 60 + int'($urandom % 81);
            repeat (delay) @(posedge clk);
            send_byte(KEY_SPACE);
            wait (o_state != ST_FIGHT);
            @(negedge clk);
            if (o_state == ST_HOME) begin
                killed = 1'b1;
            end else begin
                wait_state(ST_MENU, `ATTACK_CYCLES + 4, "monster turn");
            end
            fights++;
        end
        if (!killed) begin
            tb_errors++;
            $display("error: monster not defeated after %0d fights", fights);
        end

        send_byte(KEY_ENTER);
        wait_state(ST_MENU, BYTE_CYCLES, "enter after kill");
        repeat (10) @(posedge clk);

        total = tb_errors + UUT.u_chk.fail_count;
        $display("errors: %0d assertion, %0d testbench", UUT.u_chk.fail_count, tb_errors);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/key_pkg.sv
rtl/battle_pkg.sv
rtl/uart_key_rx.sv
rtl/key_queue.sv
rtl/battle_controller.sv
rtl/battle_top.sv
verif/battle_chk.sv
verif/battle_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= battle_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass when the log holds the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
